// File: src/icache_pkg.sv
package icache_pkg;

    // Byte address and instruction word, both one 32-bit word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // Line request to the memory controller
    // req is held for the whole transfer, addr is the first word wanted
    typedef struct packed {
        logic  req;
        addr_t addr;
    } mem_req_t;

    // One strobe per delivered word
    typedef struct packed {
        logic  valid;
        word_t data;
    } mem_rsp_t;

    // Response to the fetch unit, ready is a one-cycle strobe
    typedef struct packed {
        logic  ready;
        word_t instr;
    } fetch_rsp_t;

endpackage

// File: src/icache_tag_array.sv
`timescale 1ns/1ns

module icache_tag_array #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  logic                        Clk,
    input  logic                        arst_n,
    input  icache_pkg::addr_t           lookup_addr,
    output logic                        hit,
    output logic [$clog2(NUM_WAYS)-1:0] hit_way,
    output logic [$clog2(NUM_WAYS)-1:0] victim_way,
    input  logic                        fill_en,
    input  icache_pkg::addr_t           fill_addr,
    input  logic [$clog2(NUM_WAYS)-1:0] fill_way
);

    localparam int WAY_W = $clog2(NUM_WAYS);
    localparam int OFF_W = $clog2(BLOCK_WORDS) + 2;
    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = 32 - OFF_W - IDX_W;

    logic [TAG_W-1:0]    tags   [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid  [NUM_SETS];
    logic [WAY_W-1:0]    rr_ptr [NUM_SETS];

    logic [NUM_WAYS-1:0] way_hit;
    logic [IDX_W-1:0]    lk_set;
    logic [TAG_W-1:0]    lk_tag;
    logic [IDX_W-1:0]    fl_set;
    logic [TAG_W-1:0]    fl_tag;

    assign lk_set = lookup_addr[OFF_W +: IDX_W];
    assign lk_tag = lookup_addr[OFF_W + IDX_W +: TAG_W];
    assign fl_set = fill_addr[OFF_W +: IDX_W];
    assign fl_tag = fill_addr[OFF_W + IDX_W +: TAG_W];

    // Parallel compare over all ways of the looked-up set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = valid[lk_set][w] && (tags[lk_set][w] == lk_tag);
            if (way_hit[w]) begin
                hit_way = WAY_W'(w);
            end
        end
    end

    assign hit = |way_hit;

    // Lowest invalid way wins, else the round-robin pointer of the set
    always_comb begin
        victim_way = rr_ptr[lk_set];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid[lk_set][w]) begin
                victim_way = WAY_W'(w);
            end
        end
    end

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s]  <= '0;
                rr_ptr[s] <= '0;
            end
        end else if (fill_en) begin
            valid[fl_set][fill_way] <= 1'b1;
            rr_ptr[fl_set]          <= rr_ptr[fl_set] + 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (fill_en) begin
            tags[fl_set][fill_way] <= fl_tag;
        end
    end

    // A line is never filled twice into the same set
    a_single_hit: assert property (@(posedge Clk) disable iff (!arst_n)
        $onehot0(way_hit));

endmodule

// File: src/icache_data_array.sv
`timescale 1ns/1ns

module icache_data_array #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  logic                                    Clk,
    input  icache_pkg::addr_t                       rd_addr,
    input  logic [$clog2(NUM_WAYS)-1:0]             rd_way,
    output icache_pkg::word_t                       rd_word,
    input  logic                                    fill_en,
    input  icache_pkg::addr_t                       fill_addr,
    input  logic [$clog2(NUM_WAYS)-1:0]             fill_way,
    input  icache_pkg::word_t [BLOCK_WORDS-1:0]     fill_line
);

    import icache_pkg::*;

    localparam int WRD_W = $clog2(BLOCK_WORDS);
    localparam int OFF_W = WRD_W + 2;
    localparam int IDX_W = $clog2(NUM_SETS);

    word_t mem [NUM_SETS][NUM_WAYS][BLOCK_WORDS];

    logic [IDX_W-1:0] rd_set;
    logic [WRD_W-1:0] rd_off;
    logic [IDX_W-1:0] fl_set;

    assign rd_set = rd_addr[OFF_W +: IDX_W];
    assign rd_off = rd_addr[2 +: WRD_W];
    assign fl_set = fill_addr[OFF_W +: IDX_W];

    assign rd_word = mem[rd_set][rd_way][rd_off];

    // Whole line written at once
    always_ff @(posedge Clk) begin
        if (fill_en) begin
            for (int w = 0; w < BLOCK_WORDS; w++) begin
                mem[fl_set][fill_way][w] <= fill_line[w];
            end
        end
    end

endmodule

// File: src/icache_prefetch_buf.sv
`timescale 1ns/1ns

module icache_prefetch_buf #(
    parameter int BLOCK_WORDS = 4
) (
    input  logic                                Clk,
    input  logic                                arst_n,
    input  logic                                pf_start,
    input  icache_pkg::addr_t                   pf_addr,
    input  icache_pkg::mem_rsp_t                mem_rsp,
    input  icache_pkg::addr_t                   lookup_addr,
    input  logic                                pf_consume,
    output logic                                pf_hit,
    output icache_pkg::word_t                   pf_word,
    output icache_pkg::word_t [BLOCK_WORDS-1:0] pf_line,
    output icache_pkg::addr_t                   pf_line_addr,
    output logic                                pf_busy
);

    localparam int CNT_W = $clog2(BLOCK_WORDS);
    localparam int OFF_W = CNT_W + 2;

    logic [CNT_W-1:0] wr_cnt;
    logic             pf_valid;
    logic             last_word;

    assign last_word = pf_busy && mem_rsp.valid && (wr_cnt == CNT_W'(BLOCK_WORDS - 1));

    // Match on line address only
    assign pf_hit  = pf_valid && (lookup_addr[31:OFF_W] == pf_line_addr[31:OFF_W]);
    assign pf_word = pf_line[lookup_addr[2 +: CNT_W]];

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            pf_busy  <= 1'b0;
            pf_valid <= 1'b0;
            wr_cnt   <= '0;
        end else if (pf_start) begin
            pf_busy  <= 1'b1;
            pf_valid <= 1'b0;
            wr_cnt   <= '0;
        end else begin
            if (pf_busy && mem_rsp.valid) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (last_word) begin
                pf_busy  <= 1'b0;
                pf_valid <= 1'b1;
            end else if (pf_consume) begin
                pf_valid <= 1'b0;
            end
        end
    end

    // Prefetch lines are aligned, so words come in plain order
    always_ff @(posedge Clk) begin
        if (pf_start) begin
            pf_line_addr <= {pf_addr[31:OFF_W], {OFF_W{1'b0}}};
        end
        if (pf_busy && mem_rsp.valid) begin
            pf_line[wr_cnt] <= mem_rsp.data;
        end
    end

    // Controller only launches once the port is free
    a_no_overlap: assert property (@(posedge Clk) disable iff (!arst_n)
        pf_start |-> !pf_busy);

endmodule

// File: src/icache_ctrl.sv
`timescale 1ns/1ns

module icache_ctrl #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4,
    parameter bit PREFETCH_EN = 1
) (
    input  logic                                Clk,
    input  logic                                arst_n,
    input  logic                                read_en,
    input  icache_pkg::addr_t                   read_addr,
    input  logic                                flush,
    output icache_pkg::fetch_rsp_t              fetch_rsp,
    output logic                                busy,
    output icache_pkg::mem_req_t                mem_req,
    input  icache_pkg::mem_rsp_t                mem_rsp,
    output icache_pkg::addr_t                   lookup_addr,
    input  logic                                hit,
    input  logic [$clog2(NUM_WAYS)-1:0]         hit_way,
    input  logic [$clog2(NUM_WAYS)-1:0]         victim_way,
    input  icache_pkg::word_t                   rd_word,
    output logic [$clog2(NUM_WAYS)-1:0]         rd_way,
    input  logic                                pf_hit,
    input  icache_pkg::word_t                   pf_word,
    input  icache_pkg::word_t [BLOCK_WORDS-1:0] pf_line,
    input  icache_pkg::addr_t                   pf_line_addr,
    input  logic                                pf_busy,
    output logic                                pf_start,
    output icache_pkg::addr_t                   pf_addr,
    output logic                                pf_consume,
    output logic                                fill_en,
    output icache_pkg::addr_t                   fill_addr,
    output logic [$clog2(NUM_WAYS)-1:0]         fill_way,
    output icache_pkg::word_t [BLOCK_WORDS-1:0] fill_line
);

    import icache_pkg::*;

    localparam int    CNT_W      = $clog2(BLOCK_WORDS);
    localparam int    OFF_W      = CNT_W + 2;
    localparam addr_t LINE_BYTES = addr_t'(BLOCK_WORDS * 4);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REFILL,
        ST_WAIT_PF
    } state_t;

    state_t                  state;
    addr_t                   req_addr;
    logic                    demand_req;
    logic                    flushed;
    logic                    rsp_ready;
    word_t                   rsp_instr;
    logic [CNT_W-1:0]        word_cnt;
    logic [CNT_W-1:0]        next_off;
    logic [CNT_W-1:0]        crit_off;
    logic [CNT_W-1:0]        slot;
    word_t [BLOCK_WORDS-1:0] line_buf;
    word_t [BLOCK_WORDS-1:0] line_next;

    logic accept;
    logic pf_idle;
    logic lookup_now;
    logic pf_use;
    logic take_pf;
    logic refill_word;
    logic refill_last;

    assign accept      = read_en && !busy;
    // A prefetch is in flight from the launch strobe until its last word
    assign pf_idle     = !pf_busy && !pf_start;
    assign lookup_now  = accept || (state == ST_WAIT_PF && pf_idle);
    assign pf_use      = PREFETCH_EN && pf_hit && !hit;
    assign take_pf     = lookup_now && pf_use;
    assign refill_word = (state == ST_REFILL) && mem_rsp.valid;
    assign refill_last = refill_word && (word_cnt == CNT_W'(BLOCK_WORDS - 1));

    assign lookup_addr = (state == ST_IDLE) ? read_addr : req_addr;
    assign rd_way      = hit_way;

    // Critical word goes to its own offset, the rest fill ascending and skip it
    assign crit_off = req_addr[2 +: CNT_W];
    always_comb begin
        if (word_cnt == '0) begin
            slot = crit_off;
        end else if (next_off == crit_off) begin
            slot = next_off + 1'b1;
        end else begin
            slot = next_off;
        end
        line_next = line_buf;
        line_next[slot] = mem_rsp.data;
    end

    // Refill completion and prefetch hits both write the victim way
    assign fill_en    = refill_last || take_pf;
    assign fill_addr  = (state == ST_REFILL) ? req_addr : pf_line_addr;
    assign fill_way   = victim_way;
    assign fill_line  = (state == ST_REFILL) ? line_next : pf_line;
    assign pf_consume = take_pf;

    assign mem_req   = '{req: demand_req || pf_busy,
                         addr: demand_req ? req_addr : pf_line_addr};
    assign fetch_rsp = '{ready: rsp_ready, instr: rsp_instr};

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ST_IDLE;
            busy       <= 1'b0;
            demand_req <= 1'b0;
            flushed    <= 1'b0;
            rsp_ready  <= 1'b0;
            pf_start   <= 1'b0;
            word_cnt   <= '0;
            next_off   <= '0;
        end else begin
            rsp_ready <= 1'b0;
            pf_start  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        flushed <= flush;
                        if (hit || pf_use) begin
                            rsp_ready <= !flush;
                        end else if (!pf_idle) begin
                            busy  <= 1'b1;
                            state <= ST_WAIT_PF;
                        end else begin
                            busy       <= 1'b1;
                            demand_req <= 1'b1;
                            word_cnt   <= '0;
                            next_off   <= '0;
                            state      <= ST_REFILL;
                        end
                    end
                end
                ST_WAIT_PF: begin
                    if (flush) begin
                        flushed <= 1'b1;
                    end
                    // Repeat the lookup once the prefetch line has landed
                    if (pf_idle) begin
                        if (pf_use) begin
                            rsp_ready <= !(flush || flushed);
                            busy      <= 1'b0;
                            state     <= ST_IDLE;
                        end else begin
                            demand_req <= 1'b1;
                            word_cnt   <= '0;
                            next_off   <= '0;
                            state      <= ST_REFILL;
                        end
                    end
                end
                ST_REFILL: begin
                    if (flush) begin
                        flushed <= 1'b1;
                    end
                    if (mem_rsp.valid) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (word_cnt == '0) begin
                            rsp_ready <= !(flush || flushed);
                        end else begin
                            next_off <= slot + 1'b1;
                        end
                    end
                    if (refill_last) begin
                        demand_req <= 1'b0;
                        busy       <= 1'b0;
                        pf_start   <= PREFETCH_EN;
                        state      <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
            // Replace the consumed line with the one after it
            if (take_pf && pf_idle) begin
                pf_start <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (accept) begin
            req_addr <= read_addr;
        end
        if (lookup_now) begin
            rsp_instr <= pf_use ? pf_word : rd_word;
        end
        if (refill_word) begin
            line_buf <= line_next;
            if (word_cnt == '0) begin
                rsp_instr <= mem_rsp.data;
            end
        end
        if (refill_last) begin
            pf_addr <= {req_addr[31:OFF_W], {OFF_W{1'b0}}} + LINE_BYTES;
        end else if (take_pf) begin
            pf_addr <= pf_line_addr + LINE_BYTES;
        end
    end

    // Memory sees one address per transfer, demand and prefetch never abut
    a_req_stable: assert property (@(posedge Clk) disable iff (!arst_n)
        mem_req.req && $past(mem_req.req) |-> $stable(mem_req.addr));

endmodule

// File: src/icache_top.sv
`timescale 1ns/1ns

module icache_top #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4,
    parameter bit PREFETCH_EN = 1
) (
    input  logic                   Clk,
    input  logic                   arst_n,
    input  logic                   read_en,
    input  icache_pkg::addr_t      read_addr,
    input  logic                   flush,
    output icache_pkg::fetch_rsp_t fetch_rsp,
    output logic                   busy,
    output icache_pkg::mem_req_t   mem_req,
    input  icache_pkg::mem_rsp_t   mem_rsp
);

    import icache_pkg::*;

    localparam int WAY_W = $clog2(NUM_WAYS);

    addr_t                   lookup_addr;
    logic                    hit;
    logic [WAY_W-1:0]        hit_way;
    logic [WAY_W-1:0]        victim_way;
    logic [WAY_W-1:0]        rd_way;
    word_t                   rd_word;
    logic                    pf_hit;
    word_t                   pf_word;
    word_t [BLOCK_WORDS-1:0] pf_line;
    addr_t                   pf_line_addr;
    logic                    pf_busy;
    logic                    pf_start;
    addr_t                   pf_addr;
    logic                    pf_consume;
    logic                    fill_en;
    addr_t                   fill_addr;
    logic [WAY_W-1:0]        fill_way;
    word_t [BLOCK_WORDS-1:0] fill_line;

    icache_ctrl #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS),
        .PREFETCH_EN (PREFETCH_EN)
    ) u_ctrl (
        .Clk          (Clk),
        .arst_n       (arst_n),
        .read_en      (read_en),
        .read_addr    (read_addr),
        .flush        (flush),
        .fetch_rsp    (fetch_rsp),
        .busy         (busy),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .lookup_addr  (lookup_addr),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .rd_word      (rd_word),
        .rd_way       (rd_way),
        .pf_hit       (pf_hit),
        .pf_word      (pf_word),
        .pf_line      (pf_line),
        .pf_line_addr (pf_line_addr),
        .pf_busy      (pf_busy),
        .pf_start     (pf_start),
        .pf_addr      (pf_addr),
        .pf_consume   (pf_consume),
        .fill_en      (fill_en),
        .fill_addr    (fill_addr),
        .fill_way     (fill_way),
        .fill_line    (fill_line)
    );

    icache_tag_array #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_tags (
        .Clk         (Clk),
        .arst_n      (arst_n),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .fill_en     (fill_en),
        .fill_addr   (fill_addr),
        .fill_way    (fill_way)
    );

    icache_data_array #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_data (
        .Clk       (Clk),
        .rd_addr   (lookup_addr),
        .rd_way    (rd_way),
        .rd_word   (rd_word),
        .fill_en   (fill_en),
        .fill_addr (fill_addr),
        .fill_way  (fill_way),
        .fill_line (fill_line)
    );

    icache_prefetch_buf #(
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_pf (
        .Clk          (Clk),
        .arst_n       (arst_n),
        .pf_start     (pf_start),
        .pf_addr      (pf_addr),
        .mem_rsp      (mem_rsp),
        .lookup_addr  (lookup_addr),
        .pf_consume   (pf_consume),
        .pf_hit       (pf_hit),
        .pf_word      (pf_word),
        .pf_line      (pf_line),
        .pf_line_addr (pf_line_addr),
        .pf_busy      (pf_busy)
    );

endmodule

// File: tb/icache_mem_model.sv
`timescale 1ns/1ns

module icache_mem_model #(
    parameter int BLOCK_WORDS = 4,
    parameter int MAX_IDLE    = 2
) (
    input  logic                 Clk,
    input  logic                 arst_n,
    input  icache_pkg::mem_req_t mem_req,
    output icache_pkg::mem_rsp_t mem_rsp,
    output int                   lines_done
);

    import icache_pkg::*;

    localparam addr_t LINE_BYTES = addr_t'(BLOCK_WORDS * 4);

    addr_t first_addr;
    addr_t base_addr;
    int    sent;

    // Instruction content is a fixed mix of the whole byte address
    function automatic word_t word_at(input addr_t a);
        return (a * 32'h9E37_79B1) ^ 32'h5A3C_0F96 ^ {a[15:0], a[31:16]};
    endfunction

    // One word per strobe after a random number of idle cycles
    task automatic send_word(input addr_t a, input bit last);
        repeat ($urandom_range(0, MAX_IDLE)) @(negedge Clk);
        mem_rsp.valid = 1'b1;
        mem_rsp.data  = word_at(a);
        @(posedge Clk);
        if (last) begin
            lines_done = lines_done + 1;
        end
        @(negedge Clk);
        mem_rsp.valid = 1'b0;
    endtask

    initial begin
        mem_rsp    = '0;
        lines_done = 0;
        forever begin
            @(negedge Clk);
            if (arst_n && mem_req.req) begin
                first_addr = mem_req.addr;
                base_addr  = first_addr & ~(LINE_BYTES - 1);
                sent       = 1;
                // Critical word first, then ascending offsets around it
                send_word(first_addr, BLOCK_WORDS == 1);
                for (int k = 0; k < BLOCK_WORDS; k++) begin
                    if (base_addr + addr_t'(k * 4) != first_addr) begin
                        sent = sent + 1;
                        send_word(base_addr + addr_t'(k * 4), sent == BLOCK_WORDS);
                    end
                end
            end
        end
    end

endmodule

// File: tb/tb_icache.sv
`timescale 1ns/1ns

module tb_icache;

    import icache_pkg::*;

    localparam int NUM_SETS    = 8;
    localparam int NUM_WAYS    = 4;
    localparam int BLOCK_WORDS = 4;
    localparam bit PREFETCH_EN = 1;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_FETCHES  = 400;
    localparam int MAX_IDLE     = 2;
    localparam int LINE_CYCLES  = BLOCK_WORDS * (MAX_IDLE + 1) + 4;
    localparam int FETCH_CYCLES = 2 * LINE_CYCLES + 8;
    localparam int WATCHDOG_NS  = (NUM_FETCHES * FETCH_CYCLES + RESET_CYCLES + 50) * CLK_PERIOD;

    localparam int    OFF_W      = $clog2(BLOCK_WORDS) + 2;
    localparam int    IDX_W      = $clog2(NUM_SETS);
    localparam addr_t LINE_BYTES = addr_t'(BLOCK_WORDS * 4);
    localparam addr_t POOL_BASE  = 32'h0000_4000;
    localparam int    POOL_LINES = 48;

    logic       Clk;
    logic       arst_n;
    logic       read_en;
    addr_t      read_addr;
    logic       flush;
    fetch_rsp_t fetch_rsp;
    logic       busy;
    mem_req_t   mem_req;
    mem_rsp_t   mem_rsp;
    int         lines_done;

    // Reference copy of the tag state and the prefetch buffer
    addr_t ref_tag   [NUM_SETS][NUM_WAYS];
    bit    ref_valid [NUM_SETS][NUM_WAYS];
    int    ref_rr    [NUM_SETS];
    addr_t pf_line;
    bit    pf_have;
    int    xfers;
    int    err_count;

    icache_top #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS),
        .PREFETCH_EN (PREFETCH_EN)
    ) uut (
        .Clk       (Clk),
        .arst_n    (arst_n),
        .read_en   (read_en),
        .read_addr (read_addr),
        .flush     (flush),
        .fetch_rsp (fetch_rsp),
        .busy      (busy),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    icache_mem_model #(
        .BLOCK_WORDS (BLOCK_WORDS),
        .MAX_IDLE    (MAX_IDLE)
    ) u_mem (
        .Clk        (Clk),
        .arst_n     (arst_n),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .lines_done (lines_done)
    );

    always #(CLK_PERIOD / 2) Clk = ~Clk;

    function automatic addr_t line_of(input addr_t a);
        return {a[31:OFF_W], {OFF_W{1'b0}}};
    endfunction

    function automatic int set_of(input addr_t a);
        return int'(a[OFF_W +: IDX_W]);
    endfunction

    function automatic addr_t tag_of(input addr_t a);
        return a >> (OFF_W + IDX_W);
    endfunction

    // Same address mix as the memory model defines
    function automatic word_t expected_instr(input addr_t a);
        return (a * 32'h9E37_79B1) ^ 32'h5A3C_0F96 ^ {a[15:0], a[31:16]};
    endfunction

    function automatic fetch_rsp_t make_rsp(input logic ready, input word_t instr);
        fetch_rsp_t r;
        r.ready = ready;
        r.instr = instr;
        return r;
    endfunction

    function automatic mem_req_t make_req(input logic req, input addr_t a);
        mem_req_t r;
        r.req  = req;
        r.addr = a;
        return r;
    endfunction

    function automatic bit is_cached(input addr_t a);
        bit found;
        found = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ref_valid[set_of(a)][w] && ref_tag[set_of(a)][w] == tag_of(a)) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // Lowest invalid way, else the set's round-robin pointer
    function automatic void record_fill(input addr_t a);
        int s;
        int victim;
        s      = set_of(a);
        victim = ref_rr[s];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!ref_valid[s][w]) begin
                victim = w;
            end
        end
        ref_valid[s][victim] = 1'b1;
        ref_tag[s][victim]   = tag_of(a);
        ref_rr[s]            = (ref_rr[s] + 1) % NUM_WAYS;
    endfunction

    // Port is only busy while a prefetch has not landed
    function automatic mem_req_t idle_port_req();
        if (pf_have && lines_done < xfers) begin
            return make_req(1'b1, pf_line);
        end
        return make_req(1'b0, '0);
    endfunction

    task automatic halt_with_failure();
        err_count = err_count + 1;
        $display("tests failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_fetch(input fetch_rsp_t exp, input string what);
        if (fetch_rsp.ready !== exp.ready || (exp.ready && fetch_rsp.instr !== exp.instr)) begin
            $display("[ERROR] %0t: %s: ready=%0b instr=%h, expected ready=%0b instr=%h",
                     $time, what, fetch_rsp.ready, fetch_rsp.instr, exp.ready, exp.instr);
            halt_with_failure();
        end
    endtask

    task automatic check_mem_req(input mem_req_t exp, input string what);
        if (mem_req.req !== exp.req || (exp.req && mem_req.addr !== exp.addr)) begin
            $display("[ERROR] %0t: %s: req=%0b addr=%h, expected req=%0b addr=%h",
                     $time, what, mem_req.req, mem_req.addr, exp.req, exp.addr);
            halt_with_failure();
        end
    endtask

    task automatic check_busy(input logic exp, input string what);
        if (busy !== exp) begin
            $display("[ERROR] %0t: %s: busy=%0b, expected %0b", $time, what, busy, exp);
            halt_with_failure();
        end
    endtask

    task automatic run_fetch(input addr_t a);
        bit         cached;
        bit         landed;
        bit         use_pf;
        bit         slow;
        bit         do_flush;
        bit         got_ready;
        int         cycles;
        fetch_rsp_t exp_rsp;

        cached   = is_cached(a);
        landed   = pf_have && (lines_done >= xfers);
        use_pf   = !cached && pf_have && (line_of(a) == pf_line);
        slow     = !cached && !(use_pf && landed);
        do_flush = slow && ($urandom_range(0, 4) == 0);
        exp_rsp  = make_rsp(1'b1, expected_instr(a));

        read_en   = 1'b1;
        read_addr = a;
        @(negedge Clk);
        read_en = 1'b0;
        flush   = do_flush;

        if (!slow) begin
            check_fetch(exp_rsp, "one-cycle fetch");
            check_busy(1'b0, "one-cycle fetch");
            check_mem_req(idle_port_req(), "no demand request on a hit");
            if (use_pf) begin
                record_fill(pf_line);
                pf_line = pf_line + LINE_BYTES;
                xfers   = xfers + 1;
            end
        end else begin
            check_fetch(make_rsp(1'b0, '0), "slow fetch start");
            check_busy(1'b1, "slow fetch start");
            if (pf_have && !landed) begin
                check_mem_req(idle_port_req(), "fetch waiting on prefetch");
            end else begin
                check_mem_req(make_req(1'b1, a), "miss request");
            end
            got_ready = 1'b0;
            cycles    = 0;
            while (busy) begin
                @(negedge Clk);
                flush  = 1'b0;
                cycles = cycles + 1;
                if (fetch_rsp.ready) begin
                    if (do_flush || got_ready) begin
                        check_fetch(make_rsp(1'b0, '0), "response after flush or repeat");
                    end else begin
                        check_fetch(exp_rsp, "refill response");
                    end
                    got_ready = 1'b1;
                end
                if (cycles > FETCH_CYCLES) begin
                    $display("Fetch of %h did not finish within %0d cycles", a, FETCH_CYCLES);
                    halt_with_failure();
                end
            end
            if (!do_flush && !got_ready) begin
                $display("Fetch of %h finished without any response", a);
                halt_with_failure();
            end
            if (use_pf) begin
                record_fill(pf_line);
                pf_line = pf_line + LINE_BYTES;
                xfers   = xfers + 1;
            end else begin
                xfers = xfers + 1;
                record_fill(a);
                if (PREFETCH_EN) begin
                    pf_line = line_of(a) + LINE_BYTES;
                    pf_have = 1'b1;
                    xfers   = xfers + 1;
                end
            end
            // Prefetch launch needs one cycle to reach the port
            @(negedge Clk);
            check_fetch(make_rsp(1'b0, '0), "no response after refill");
            if (PREFETCH_EN) begin
                check_mem_req(make_req(1'b1, pf_line), "prefetch of the next line");
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with fetches still running", WATCHDOG_NS);
        halt_with_failure();
    end

    initial begin
        addr_t cur;
        int    r;

        Clk       = 1'b0;
        arst_n    = 1'b0;
        read_en   = 1'b0;
        read_addr = '0;
        flush     = 1'b0;
        err_count = 0;
        pf_have   = 1'b0;
        pf_line   = '0;
        xfers     = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            ref_rr[s] = 0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
            end
        end
        void'($urandom(22));

        repeat (RESET_CYCLES) @(negedge Clk);
        arst_n = 1'b1;
        @(negedge Clk);
        check_fetch(make_rsp(1'b0, '0), "after reset");
        check_busy(1'b0, "after reset");
        check_mem_req(make_req(1'b0, '0), "after reset");

        cur = POOL_BASE;
        for (int n = 0; n < NUM_FETCHES; n++) begin
            r = $urandom_range(0, 9);
            if (n > 0 && r < 6) begin
                // Sequential runs walk into the prefetched line
                if (cur + 4 >= POOL_BASE + addr_t'(POOL_LINES) * LINE_BYTES) begin
                    cur = POOL_BASE;
                end else begin
                    cur = cur + 4;
                end
            end else if (n == 0 || r > 6) begin
                cur = POOL_BASE + addr_t'($urandom_range(0, POOL_LINES * BLOCK_WORDS - 1)) * 4;
            end
            run_fetch(cur);
            repeat ($urandom_range(0, 2)) begin
                @(negedge Clk);
                // No response without a fetch
                check_fetch(make_rsp(1'b0, '0), "idle gap");
            end
        end

        read_en = 1'b0;
        repeat (2) @(negedge Clk);
        if (err_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: sources.f
src/icache_pkg.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/icache_prefetch_buf.sv
src/icache_ctrl.sv
src/icache_top.sv
tb/icache_mem_model.sv
tb/tb_icache.sv
